// ==== dv/rv_core_stim.txt ====
# T <test number> starts a test, P <word index> <instruction> loads one program word
# S <byte address> <data> is the next expected store in program order, all values hex
# Test 1: no store at all
T 1
P 00 00500093 # addi x1, x0, 5
P 01 00108113 # addi x2, x1, 1
P 02 00000063 # beq x0, x0, 0
# Test 2: register-register operations on a negative operand
T 2
P 00 FF900093 # addi x1, x0, -7
P 01 00300113 # addi x2, x0, 3
P 02 402081B3 # sub x3, x1, x2
P 03 10302023 # sw x3, 0x100(x0)
P 04 4020D233 # sra x4, x1, x2
P 05 10402223 # sw x4, 0x104(x0)
P 06 0020A2B3 # slt x5, x1, x2
P 07 0020B333 # sltu x6, x1, x2
P 08 10502423 # sw x5, 0x108(x0)
P 09 10602623 # sw x6, 0x10c(x0)
P 0A 0020D3B3 # srl x7, x1, x2
P 0B 0013C433 # xor x8, x7, x1
P 0C 10802823 # sw x8, 0x110(x0)
P 0D 002114B3 # sll x9, x2, x2
P 0E 0024E533 # or x10, x9, x2
P 0F 001575B3 # and x11, x10, x1
P 10 00158633 # add x12, x11, x1
P 11 10C02A23 # sw x12, 0x114(x0)
P 12 00000063 # beq x0, x0, 0
S 00000100 FFFFFFF6
S 00000104 FFFFFFFF
S 00000108 00000001
S 0000010C 00000000
S 00000110 E0000006
S 00000114 00000012
# Test 3: immediate forms, negative I and S immediates
T 3
P 00 20000093 # addi x1, x0, 0x200
P 01 FFF0C113 # xori x2, x1, -1
P 02 FE20AE23 # sw x2, -4(x1)
P 03 40415193 # srai x3, x2, 4
P 04 FE01A213 # slti x4, x3, -32
P 05 0051B293 # sltiu x5, x3, 5
P 06 01C1D313 # srli x6, x3, 28
P 07 00831393 # slli x7, x6, 8
P 08 0A53E413 # ori x8, x7, 0xa5
P 09 03C47493 # andi x9, x8, 0x3c
P 0A 0040A423 # sw x4, 8(x1)
P 0B 0050A623 # sw x5, 12(x1)
P 0C 8090A023 # sw x9, -2048(x1)
P 0D 00000063 # beq x0, x0, 0
S 000001FC FFFFFDFF
S 00000208 00000001
S 0000020C 00000000
S FFFFFA00 00000024
# Test 4: forwarding from both stages, load-use stall, register-file bypass
T 4
P 00 00500093 # addi x1, x0, 5
P 01 00108093 # addi x1, x1, 1
P 02 00208113 # addi x2, x1, 2
P 03 002081B3 # add x3, x1, x2
P 04 04302023 # sw x3, 0x40(x0)
P 05 04002203 # lw x4, 0x40(x0)
P 06 00320293 # addi x5, x4, 3
P 07 04502223 # sw x5, 0x44(x0)
P 08 07700313 # addi x6, x0, 0x77
P 09 00100393 # addi x7, x0, 1
P 0A 00200413 # addi x8, x0, 2
P 0B 000304B3 # add x9, x6, x0
P 0C 04902423 # sw x9, 0x48(x0)
P 0D 00000063 # beq x0, x0, 0
S 00000040 0000000E
S 00000044 00000011
S 00000048 00000077
# Test 5: all six branch types taken and not taken, taken ones skip a store
T 5
P 00 FFF00093 # addi x1, x0, -1
P 01 00100113 # addi x2, x0, 1
P 02 00108463 # beq x1, x1, +8 taken
P 03 30102023 # sw x1, 0x300(x0)
P 04 00109463 # bne x1, x1, +8
P 05 30202223 # sw x2, 0x304(x0)
P 06 0020C463 # blt x1, x2, +8 taken
P 07 30102423 # sw x1, 0x308(x0)
P 08 0020E463 # bltu x1, x2, +8
P 09 30102623 # sw x1, 0x30c(x0)
P 0A 00115463 # bge x2, x1, +8 taken
P 0B 30202823 # sw x2, 0x310(x0)
P 0C 00117463 # bgeu x2, x1, +8
P 0D 30202A23 # sw x2, 0x314(x0)
P 0E 0020F463 # bgeu x1, x2, +8 taken
P 0F 30102C23 # sw x1, 0x318(x0)
P 10 00114463 # blt x2, x1, +8
P 11 30102E23 # sw x1, 0x31c(x0)
P 12 00209463 # bne x1, x2, +8 taken
P 13 32202023 # sw x2, 0x320(x0)
P 14 00116463 # bltu x2, x1, +8 taken
P 15 32202223 # sw x2, 0x324(x0)
P 16 0020D463 # bge x1, x2, +8
P 17 32202423 # sw x2, 0x328(x0)
P 18 00208463 # beq x1, x2, +8
P 19 32102623 # sw x1, 0x32c(x0)
P 1A 00000063 # beq x0, x0, 0
S 00000304 00000001
S 0000030C FFFFFFFF
S 00000314 00000001
S 0000031C FFFFFFFF
S 00000328 00000001
S 0000032C FFFFFFFF

// ==== dv/rv_core_tb.sv ====
// Self-checking testbench for the core, loading programs and checking the store stream
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam string STIM_FILE     = "dv/rv_core_stim.txt";
    localparam int    STORE_TIMEOUT = 2000;
    localparam int    QUIET_CYCLES  = 50;
    localparam int    RESET_CYCLES  = 3;

    logic                       clk;
    logic                       rst_n;
    logic                       prog_we;
    logic [rv_pkg::IMEM_AW-1:0] prog_addr;
    logic [rv_pkg::XLEN-1:0]    prog_data;
    logic                       st_valid;
    logic [rv_pkg::XLEN-1:0]    st_addr;
    logic [rv_pkg::XLEN-1:0]    st_data;

    // Parsed stim file, every entry tagged with its test index
    int                      test_ids[$];
    int                      p_test[$];
    logic [rv_pkg::XLEN-1:0] p_addr[$];
    logic [rv_pkg::XLEN-1:0] p_data[$];
    int                      s_test[$];
    logic [rv_pkg::XLEN-1:0] s_addr[$];
    logic [rv_pkg::XLEN-1:0] s_data[$];

    int checks;
    int errors;

    rv_core DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .st_valid  (st_valid),
        .st_addr   (st_addr),
        .st_data   (st_data)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Stim file parsing
    // ----------------------------------------------------------
    task automatic parse_stim_file;
        int                      fd;
        int                      n;
        int                      id;
        string                   line;
        logic [rv_pkg::XLEN-1:0] a;
        logic [rv_pkg::XLEN-1:0] d;
        fd = $fopen(STIM_FILE, "r");
        assert (fd != 0) else begin
            errors++;
            $display("Could not open the stimulus file %s", STIM_FILE);
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Comment and blank lines fall through
                if (n > 0 && line.getc(0) == "T") begin
                    n = $sscanf(line, "T %d", id);
                    test_ids.push_back(id);
                end else if (n > 0 && (line.getc(0) == "P" || line.getc(0) == "S")) begin
                    if (line.getc(0) == "P") begin
                        n = $sscanf(line, "P %h %h", a, d);
                    end else begin
                        n = $sscanf(line, "S %h %h", a, d);
                    end
                    assert (n == 2 && test_ids.size() > 0) else begin
                        errors++;
                        $display("Stimulus line could not be used: %s", line);
                    end
                    if (line.getc(0) == "P") begin
                        p_test.push_back(test_ids.size() - 1);
                        p_addr.push_back(a);
                        p_data.push_back(d);
                    end else begin
                        s_test.push_back(test_ids.size() - 1);
                        s_addr.push_back(a);
                        s_data.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------------------------
    // Program load under reset
    // ----------------------------------------------------------
    // No store beat may show while the core is held in reset
    task automatic check_quiet_in_reset;
        @(negedge clk);
        assert (st_valid === 1'b0) else begin
            errors++;
            $display("ERROR at %t: st_valid is %b during reset", $time, st_valid);
        end
    endtask

    task automatic load_program(input int t);
        @(posedge clk);
        rst_n <= 1'b0;
        foreach (p_test[i]) begin
            if (p_test[i] == t) begin
                check_quiet_in_reset();
                @(posedge clk);
                prog_we   <= 1'b1;
                prog_addr <= p_addr[i][rv_pkg::IMEM_AW-1:0];
                prog_data <= p_data[i];
            end
        end
        check_quiet_in_reset();
        @(posedge clk);
        prog_we <= 1'b0;
        // Reset stays low a few cycles past the last word
        repeat (RESET_CYCLES) begin
            check_quiet_in_reset();
            @(posedge clk);
        end
        rst_n <= 1'b1;
    endtask

    // ----------------------------------------------------------
    // Store stream checking
    // ----------------------------------------------------------
    task automatic check_stores(input int t);
        logic [rv_pkg::XLEN-1:0] exp_addr[$];
        logic [rv_pkg::XLEN-1:0] exp_data[$];
        int                      idx;
        int                      cycles;
        foreach (s_test[i]) begin
            if (s_test[i] == t) begin
                exp_addr.push_back(s_addr[i]);
                exp_data.push_back(s_data[i]);
            end
        end
        idx    = 0;
        cycles = 0;
        // Sampled on the falling edge, well clear of register updates
        while (idx < exp_addr.size() && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (st_valid === 1'b1) begin
                checks++;
                assert (st_addr === exp_addr[idx]) else begin
                    errors++;
                    $display("ERROR at %t: test %0d store %0d address %h, expected %h",
                             $time, test_ids[t], idx, st_addr, exp_addr[idx]);
                end
                assert (st_data === exp_data[idx]) else begin
                    errors++;
                    $display("ERROR at %t: test %0d store %0d data %h, expected %h",
                             $time, test_ids[t], idx, st_data, exp_data[idx]);
                end
                idx++;
            end
        end
        assert (idx == exp_addr.size()) else begin
            errors++;
            $display("Test %0d timed out: only %0d of %0d stores arrived within %0d cycles",
                     test_ids[t], idx, exp_addr.size(), STORE_TIMEOUT);
        end
        // Program now spins on its final branch, so the store port stays idle
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            assert (st_valid === 1'b0) else begin
                errors++;
                $display("Test %0d made an unexpected extra store to %h with data %h at %t",
                         test_ids[t], st_addr, st_data, $time);
            end
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        checks    = 0;
        errors    = 0;
        parse_stim_file();
        assert (test_ids.size() > 0) else begin
            errors++;
            $display("The stimulus file holds no tests");
        end
        for (int t = 0; t < test_ids.size(); t++) begin
            $display("Running test %0d", test_ids[t]);
            load_program(t);
            check_stores(t);
        end
        $display("Store checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
src/rv_pkg.sv
src/dmem_if.sv
src/instr_decode.sv
src/alu.sv
src/reg_file.sv
src/hazard_unit.sv
src/rv_pipeline.sv
src/instr_mem.sv
src/data_mem.sv
src/rv_core.sv
dv/rv_core_tb.sv

// ==== src/alu.sv ====
// 32-bit ALU for arithmetic, logic, compare and shift operations
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_pkg::alu_op_e         op,
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    output logic [rv_pkg::XLEN-1:0] result
);

    logic [4:0] shamt;

    // Only the low five bits shift
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: result = {31'b0, a < b};
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            // Arithmetic shift keeps the sign
            rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_AND:  result = a & b;
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/data_mem.sv ====
// Data RAM for the memory stage with a registered store-observation copy
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  logic                    clk,
    input  logic                    rst_n,
    dmem_if.mem                     bus,
    output logic                    st_valid,
    output logic [rv_pkg::XLEN-1:0] st_addr,
    output logic [rv_pkg::XLEN-1:0] st_data
);

    logic [rv_pkg::XLEN-1:0]    mem [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::DMEM_AW-1:0] idx;

    assign idx       = bus.addr[rv_pkg::DMEM_AW+1:2];
    assign bus.rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[idx] <= bus.wdata;
        end
    end

    // One beat per accepted write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid <= 1'b0;
        end else begin
            st_valid <= bus.we;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.we) begin
            st_addr <= bus.addr;
            st_data <= bus.wdata;
        end
    end

    // Decoder never marks an instruction as both load and store
    a_no_read_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(bus.re && bus.we)
    );

endmodule

`default_nettype wire

// ==== src/dmem_if.sv ====
// Data-memory request and read-data bundle between the MEM stage and the RAM
`timescale 1ns/1ps
`default_nettype none

interface dmem_if;

    // Requests from the pipeline
    logic                    re;
    logic                    we;
    logic [rv_pkg::XLEN-1:0] addr;
    logic [rv_pkg::XLEN-1:0] wdata;
    // Read data, valid in the same cycle as addr
    logic [rv_pkg::XLEN-1:0] rdata;

    modport core (
        output re, we, addr, wdata,
        input  rdata
    );

    modport mem (
        input  re, we, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== src/hazard_unit.sv ====
// Forwarding source selection for execute operands and load-use stall detect
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic [rv_pkg::REG_AW-1:0] ex_rs1,
    input  logic [rv_pkg::REG_AW-1:0] ex_rs2,
    input  logic [rv_pkg::REG_AW-1:0] id_rs1,
    input  logic [rv_pkg::REG_AW-1:0] id_rs2,
    input  logic [rv_pkg::REG_AW-1:0] mem_rd,
    input  logic [rv_pkg::REG_AW-1:0] wb_rd,
    input  logic [rv_pkg::REG_AW-1:0] ex_rd,
    input  logic                      mem_reg_write,
    input  logic                      wb_reg_write,
    input  logic                      ex_mem_read,
    output rv_pkg::fwd_sel_e          fwd_a,
    output rv_pkg::fwd_sel_e          fwd_b,
    output logic                      stall
);

    logic mem_fwd_ok;
    logic wb_fwd_ok;

    // Writes to x0 never forward
    assign mem_fwd_ok = mem_reg_write && (mem_rd != '0);
    assign wb_fwd_ok  = wb_reg_write && (wb_rd != '0);

    // MEM stage holds the younger result, so it goes first
    assign fwd_a = (mem_fwd_ok && mem_rd == ex_rs1) ? rv_pkg::FWD_MEM :
                   (wb_fwd_ok && wb_rd == ex_rs1)   ? rv_pkg::FWD_WB  : rv_pkg::FWD_NONE;
    assign fwd_b = (mem_fwd_ok && mem_rd == ex_rs2) ? rv_pkg::FWD_MEM :
                   (wb_fwd_ok && wb_rd == ex_rs2)   ? rv_pkg::FWD_WB  : rv_pkg::FWD_NONE;

    // Load in execute feeding the instruction in decode
    assign stall = ex_mem_read && (ex_rd != '0) &&
                   (ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

`default_nettype wire

// ==== src/instr_decode.sv ====
// Instruction decoder producing control fields, register indices and immediate
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic [rv_pkg::XLEN-1:0]   instr,
    output rv_pkg::ctrl_t             ctrl,
    output logic [rv_pkg::REG_AW-1:0] rs1,
    output logic [rv_pkg::REG_AW-1:0] rs2,
    output logic [rv_pkg::REG_AW-1:0] rd,
    output logic [rv_pkg::XLEN-1:0]   imm
);

    logic [2:0]      funct3;
    logic            is_reg;
    rv_pkg::alu_op_e arith_op;

    assign funct3 = instr[14:12];
    assign is_reg = (instr[6:0] == rv_pkg::OP_REG);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // Shared ALU op for register and immediate arithmetic
    // instr[30] picks SUB (register form only) and SRA
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_reg && instr[30]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  arith_op = rv_pkg::ALU_SLL;
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b011:  arith_op = rv_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_pkg::ALU_XOR;
            3'b101:  arith_op = instr[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        // Unknown opcode falls through as a no-op
        ctrl = '0;
        // I format by default
        imm  = {{20{instr[31]}}, instr[31:20]};
        case (instr[6:0])
            rv_pkg::OP_REG: begin
                ctrl.alu_op    = arith_op;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::OP_IMM: begin
                ctrl.alu_op      = arith_op;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            rv_pkg::OP_LOAD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            rv_pkg::OP_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_pkg::OP_BRANCH: begin
                // Compare via subtraction in execute
                ctrl.alu_op = rv_pkg::ALU_SUB;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
                case (funct3)
                    3'b000:  ctrl.branch = rv_pkg::BR_EQ;
                    3'b001:  ctrl.branch = rv_pkg::BR_NE;
                    3'b100:  ctrl.branch = rv_pkg::BR_LT;
                    3'b101:  ctrl.branch = rv_pkg::BR_GE;
                    3'b110:  ctrl.branch = rv_pkg::BR_LTU;
                    3'b111:  ctrl.branch = rv_pkg::BR_GEU;
                    default: ctrl = '0;
                endcase
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/instr_mem.sv ====
// Instruction RAM with a program-load write port and combinational fetch
`timescale 1ns/1ps
`default_nettype none

module instr_mem (
    input  logic                       clk,
    input  logic                       we,
    input  logic [rv_pkg::IMEM_AW-1:0] waddr,
    input  logic [rv_pkg::XLEN-1:0]    wdata,
    input  logic [rv_pkg::XLEN-1:0]    raddr,
    output logic [rv_pkg::XLEN-1:0]    rdata
);

    logic [rv_pkg::XLEN-1:0] mem [rv_pkg::IMEM_WORDS];

    // Program load, one word per edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Byte address to word index
    assign rdata = mem[raddr[rv_pkg::IMEM_AW+1:2]];

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// Integer register file with zero register, two reads and write-through bypass
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [rv_pkg::REG_AW-1:0] raddr1,
    input  logic [rv_pkg::REG_AW-1:0] raddr2,
    output logic [rv_pkg::XLEN-1:0]   rdata1,
    output logic [rv_pkg::XLEN-1:0]   rdata2,
    input  logic                      we,
    input  logic [rv_pkg::REG_AW-1:0] waddr,
    input  logic [rv_pkg::XLEN-1:0]   wdata
);

    logic [rv_pkg::XLEN-1:0] regs [32];

    // x0 is never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Writeback in the same cycle wins over the stored value
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

    // Write data aimed at x0 never leaks through the bypass
    a_x0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (we && waddr == '0) |-> ((raddr1 != '0 || rdata1 == '0) &&
                                 (raddr2 != '0 || rdata2 == '0))
    );

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
// Core top level joining the pipeline with instruction and data memories
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       prog_we,
    input  logic [rv_pkg::IMEM_AW-1:0] prog_addr,
    input  logic [rv_pkg::XLEN-1:0]    prog_data,
    output logic                       st_valid,
    output logic [rv_pkg::XLEN-1:0]    st_addr,
    output logic [rv_pkg::XLEN-1:0]    st_data
);

    logic [rv_pkg::XLEN-1:0] fetch_addr;
    logic [rv_pkg::XLEN-1:0] instr;

    dmem_if u_dmem_if ();

    instr_mem u_imem (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (fetch_addr),
        .rdata (instr)
    );

    rv_pipeline u_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_addr (fetch_addr),
        .instr      (instr),
        .dmem       (u_dmem_if.core)
    );

    data_mem u_dmem (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (u_dmem_if.mem),
        .st_valid (st_valid),
        .st_addr  (st_addr),
        .st_data  (st_data)
    );

endmodule

`default_nettype wire

// ==== src/rv_pipeline.sv ====
// Five-stage in-order pipeline with forwarding, load-use stall and branch flush
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::XLEN-1:0] fetch_addr,
    input  logic [rv_pkg::XLEN-1:0] instr,
    dmem_if.core                    dmem
);

    logic [rv_pkg::XLEN-1:0]   pc;

    // IF/ID
    logic                      ifid_valid;
    logic [rv_pkg::XLEN-1:0]   ifid_pc;
    logic [rv_pkg::XLEN-1:0]   ifid_instr;

    // Decode outputs
    rv_pkg::ctrl_t             id_ctrl;
    logic [rv_pkg::REG_AW-1:0] id_rs1;
    logic [rv_pkg::REG_AW-1:0] id_rs2;
    logic [rv_pkg::REG_AW-1:0] id_rd;
    logic [rv_pkg::XLEN-1:0]   id_imm;
    logic [rv_pkg::XLEN-1:0]   id_rdata1;
    logic [rv_pkg::XLEN-1:0]   id_rdata2;

    // ID/EX
    logic                      idex_valid;
    rv_pkg::ctrl_t             idex_ctrl;
    logic [rv_pkg::XLEN-1:0]   idex_pc;
    logic [rv_pkg::REG_AW-1:0] idex_rs1;
    logic [rv_pkg::REG_AW-1:0] idex_rs2;
    logic [rv_pkg::REG_AW-1:0] idex_rd;
    logic [rv_pkg::XLEN-1:0]   idex_imm;
    logic [rv_pkg::XLEN-1:0]   idex_rdata1;
    logic [rv_pkg::XLEN-1:0]   idex_rdata2;

    // Execute
    rv_pkg::fwd_sel_e          fwd_a;
    rv_pkg::fwd_sel_e          fwd_b;
    logic                      stall;
    logic [rv_pkg::XLEN-1:0]   ex_op_a;
    logic [rv_pkg::XLEN-1:0]   ex_op_b;
    logic [rv_pkg::XLEN-1:0]   ex_result;
    logic                      ex_cond;
    logic                      ex_taken;

    // EX/MEM
    logic                      exmem_valid;
    rv_pkg::ctrl_t             exmem_ctrl;
    logic [rv_pkg::XLEN-1:0]   exmem_result;
    logic [rv_pkg::XLEN-1:0]   exmem_wdata;
    logic [rv_pkg::REG_AW-1:0] exmem_rd;

    // MEM/WB
    logic                      memwb_valid;
    rv_pkg::ctrl_t             memwb_ctrl;
    logic [rv_pkg::XLEN-1:0]   memwb_result;
    logic [rv_pkg::XLEN-1:0]   memwb_rdata;
    logic [rv_pkg::REG_AW-1:0] memwb_rd;
    logic [rv_pkg::XLEN-1:0]   wb_data;
    logic                      wb_we;

    // ----------------------------------------------------------
    // Fetch and decode
    // ----------------------------------------------------------
    assign fetch_addr = pc;

    instr_decode u_decode (
        .instr (ifid_instr),
        .ctrl  (id_ctrl),
        .rs1   (id_rs1),
        .rs2   (id_rs2),
        .rd    (id_rd),
        .imm   (id_imm)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (id_rs1),
        .raddr2 (id_rs2),
        .rdata1 (id_rdata1),
        .rdata2 (id_rdata2),
        .we     (wb_we),
        .waddr  (memwb_rd),
        .wdata  (wb_data)
    );

    // ----------------------------------------------------------
    // Execute
    // ----------------------------------------------------------
    hazard_unit u_hazard (
        .ex_rs1        (idex_rs1),
        .ex_rs2        (idex_rs2),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .mem_rd        (exmem_rd),
        .wb_rd         (memwb_rd),
        .ex_rd         (idex_rd),
        .mem_reg_write (exmem_valid && exmem_ctrl.reg_write),
        .wb_reg_write  (wb_we),
        .ex_mem_read   (idex_valid && idex_ctrl.mem_read),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .stall         (stall)
    );

    // Forwarded register operands
    assign ex_op_a = (fwd_a == rv_pkg::FWD_MEM) ? exmem_result :
                     (fwd_a == rv_pkg::FWD_WB)  ? wb_data : idex_rdata1;
    assign ex_op_b = (fwd_b == rv_pkg::FWD_MEM) ? exmem_result :
                     (fwd_b == rv_pkg::FWD_WB)  ? wb_data : idex_rdata2;

    alu u_alu (
        .op     (idex_ctrl.alu_op),
        .a      (ex_op_a),
        .b      (idex_ctrl.alu_src_imm ? idex_imm : ex_op_b),
        .result (ex_result)
    );

    // Equality from the ALU difference, ordering from the operands
    always_comb begin
        case (idex_ctrl.branch)
            rv_pkg::BR_EQ:  ex_cond = (ex_result == '0);
            rv_pkg::BR_NE:  ex_cond = (ex_result != '0);
            rv_pkg::BR_LT:  ex_cond = ($signed(ex_op_a) < $signed(ex_op_b));
            rv_pkg::BR_GE:  ex_cond = ($signed(ex_op_a) >= $signed(ex_op_b));
            rv_pkg::BR_LTU: ex_cond = (ex_op_a < ex_op_b);
            rv_pkg::BR_GEU: ex_cond = (ex_op_a >= ex_op_b);
            default:        ex_cond = 1'b0;
        endcase
    end

    assign ex_taken = idex_valid && ex_cond;

    // ----------------------------------------------------------
    // Pipeline control
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            ifid_valid  <= 1'b0;
            idex_valid  <= 1'b0;
            idex_ctrl   <= '0;
            exmem_valid <= 1'b0;
            exmem_ctrl  <= '0;
            memwb_valid <= 1'b0;
            memwb_ctrl  <= '0;
        end else begin
            exmem_valid <= idex_valid;
            exmem_ctrl  <= idex_ctrl;
            memwb_valid <= exmem_valid;
            memwb_ctrl  <= exmem_ctrl;
            if (ex_taken) begin
                // Redirect and kill the two younger instructions
                pc         <= idex_pc + idex_imm;
                ifid_valid <= 1'b0;
                idex_valid <= 1'b0;
            end else if (stall) begin
                // PC and IF/ID hold, bubble into execute
                idex_valid <= 1'b0;
            end else begin
                pc         <= pc + 32'd4;
                ifid_valid <= 1'b1;
                idex_valid <= ifid_valid;
                idex_ctrl  <= id_ctrl;
            end
        end
    end

    // Payload, qualified by the valid bits
    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_pc    <= pc;
            ifid_instr <= instr;
        end
        idex_pc      <= ifid_pc;
        idex_rs1     <= id_rs1;
        idex_rs2     <= id_rs2;
        idex_rd      <= id_rd;
        idex_imm     <= id_imm;
        idex_rdata1  <= id_rdata1;
        idex_rdata2  <= id_rdata2;
        exmem_result <= ex_result;
        exmem_wdata  <= ex_op_b;
        exmem_rd     <= idex_rd;
        memwb_result <= exmem_result;
        memwb_rdata  <= dmem.rdata;
        memwb_rd     <= exmem_rd;
    end

    // ----------------------------------------------------------
    // Memory and writeback
    // ----------------------------------------------------------
    assign dmem.re    = exmem_valid && exmem_ctrl.mem_read;
    assign dmem.we    = exmem_valid && exmem_ctrl.mem_write;
    assign dmem.addr  = exmem_result;
    assign dmem.wdata = exmem_wdata;

    assign wb_we   = memwb_valid && memwb_ctrl.reg_write;
    assign wb_data = memwb_ctrl.mem_to_reg ? memwb_rdata : memwb_result;

    // Both slots killed by a taken branch pass MEM without a request
    a_mem_req_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        ex_taken |-> ##2 !(dmem.re || dmem.we) ##1 !(dmem.re || dmem.we)
    );

    // A load in execute is never a branch at the same time
    a_no_flush_and_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ex_taken && stall)
    );

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
// RV32I subset definitions shared by the core, its pipeline and its memories
`default_nettype none

package rv_pkg;

    // ----------------------------------------------------------
    // Widths and memory depths
    // ----------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = 8;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

    // ----------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------
    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // ADD at zero so all-zero control is harmless
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE, FWD_MEM, FWD_WB
    } fwd_sel_e;

    // Decoded control, travels down the pipeline
    typedef struct packed {
        alu_op_e alu_op;
        branch_e branch;
        logic    alu_src_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
    } ctrl_t;

endpackage

`default_nettype wire
